// ==== Bender.yml ====
package:
  name: csr_unit

sources:
  - files:
      - hdl/csr_pkg.sv
      - hdl/csr_access.sv
      - hdl/csr_exc_prio.sv
      - hdl/csr_status.sv
      - hdl/csr_trap_regs.sv
      - hdl/csr_counters.sv
      - hdl/csr_top.sv
  - target: simulation
    files:
      - testbench/tb_csr_top.sv

// ==== all.f ====
hdl/csr_pkg.sv
hdl/csr_access.sv
hdl/csr_exc_prio.sv
hdl/csr_status.sv
hdl/csr_trap_regs.sv
hdl/csr_counters.sv
hdl/csr_top.sv
testbench/tb_csr_top.sv

// ==== hdl/csr_access.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_access (
    input  logic                          valid,
    input  logic                          csr_write,
    input  logic                          trap,
    input  logic [csr_pkg::csr_idx_w-1:0] csr_read_index,
    input  logic [csr_pkg::csr_idx_w-1:0] csr_write_index,
    input  logic [csr_pkg::xlen-1:0]      mstatus,
    input  logic [csr_pkg::xlen-1:0]      mtvec,
    input  logic [csr_pkg::xlen-1:0]      mscratch,
    input  logic [csr_pkg::xlen-1:0]      mepc,
    input  logic [csr_pkg::xlen-1:0]      mcause,
    input  logic [csr_pkg::xlen-1:0]      mtval,
    input  logic [csr_pkg::xlen-1:0]      mcycle,
    input  logic [csr_pkg::xlen-1:0]      minstret,
    input  logic [csr_pkg::xlen-1:0]      mcountinhibit,
    output logic                          write_mstatus,
    output logic                          write_mtvec,
    output logic                          write_mscratch,
    output logic                          write_mepc,
    output logic                          write_mcause,
    output logic                          write_mtval,
    output logic                          write_mcycle,
    output logic                          write_minstret,
    output logic                          write_mcountinhibit,
    output logic [csr_pkg::xlen-1:0]      csr_data_r
);

    logic write_en;

    // a trapping instruction never retires its CSR write
    assign write_en = valid && csr_write && !trap;

    assign write_mstatus       = write_en && (csr_write_index == csr_pkg::csr_mstatus);
    assign write_mtvec         = write_en && (csr_write_index == csr_pkg::csr_mtvec);
    assign write_mscratch      = write_en && (csr_write_index == csr_pkg::csr_mscratch);
    assign write_mepc          = write_en && (csr_write_index == csr_pkg::csr_mepc);
    assign write_mcause        = write_en && (csr_write_index == csr_pkg::csr_mcause);
    assign write_mtval         = write_en && (csr_write_index == csr_pkg::csr_mtval);
    assign write_mcycle        = write_en && (csr_write_index == csr_pkg::csr_mcycle);
    assign write_minstret      = write_en && (csr_write_index == csr_pkg::csr_minstret);
    assign write_mcountinhibit = write_en && (csr_write_index == csr_pkg::csr_mcountinhibit);

    // read mux, unknown index reads as zero
    always_comb begin
        case (csr_read_index)
            csr_pkg::csr_mstatus:       csr_data_r = mstatus;
            csr_pkg::csr_misa:          csr_data_r = csr_pkg::misa_value;
            csr_pkg::csr_mtvec:         csr_data_r = mtvec;
            csr_pkg::csr_mscratch:      csr_data_r = mscratch;
            csr_pkg::csr_mepc:          csr_data_r = mepc;
            csr_pkg::csr_mcause:        csr_data_r = mcause;
            csr_pkg::csr_mtval:         csr_data_r = mtval;
            csr_pkg::csr_mcycle,
            csr_pkg::csr_cycle:         csr_data_r = mcycle;   // user alias shares the counter
            csr_pkg::csr_minstret,
            csr_pkg::csr_instret:       csr_data_r = minstret;
            csr_pkg::csr_mcountinhibit: csr_data_r = mcountinhibit;
            csr_pkg::csr_mhartid:       csr_data_r = csr_pkg::hart_id;
            default:                    csr_data_r = '0;
        endcase
    end

    // at most one register written per instruction
    always_comb begin
        assert final ($onehot0({write_mstatus, write_mtvec, write_mscratch, write_mepc,
                                write_mcause, write_mtval, write_mcycle, write_minstret,
                                write_mcountinhibit}));
    end

endmodule

`default_nettype wire

// ==== hdl/csr_counters.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_counters (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     valid,
    input  logic                     trap,
    input  logic                     write_mcycle,
    input  logic                     write_minstret,
    input  logic                     write_mcountinhibit,
    input  logic [csr_pkg::xlen-1:0] csr_data_w,
    output logic [csr_pkg::xlen-1:0] mcycle,
    output logic [csr_pkg::xlen-1:0] minstret,
    output logic [csr_pkg::xlen-1:0] mcountinhibit
);

    logic cy_inh; // bit 0
    logic ir_inh; // bit 2

    always_ff @(posedge clk) begin
        if (rst) begin
            cy_inh <= 1'b0;
            ir_inh <= 1'b0;
        end else if (write_mcountinhibit) begin
            cy_inh <= csr_data_w[0];
            ir_inh <= csr_data_w[2];
        end
    end

    // time and hpm bits are hardwired zero
    assign mcountinhibit = {{(csr_pkg::xlen-3){1'b0}}, ir_inh, 1'b0, cy_inh};

    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle <= '0;
        end else if (write_mcycle) begin
            mcycle <= csr_data_w;
        end else if (!cy_inh) begin
            mcycle <= mcycle + 1'b1;
        end
    end

    // retired means valid and not trapped
    always_ff @(posedge clk) begin
        if (rst) begin
            minstret <= '0;
        end else if (write_minstret) begin
            minstret <= csr_data_w;
        end else if (valid && !trap && !ir_inh) begin
            minstret <= minstret + 1'b1;
        end
    end

    // an instruction that traps does not retire
    assert property (@(posedge clk) disable iff (rst)
        (valid && trap && !write_minstret) |=> minstret == $past(minstret));

endmodule

`default_nettype wire

// ==== hdl/csr_exc_prio.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_exc_prio (
    input  logic                       valid,
    input  logic                       ins_addr_mis,
    input  logic                       ill_ins,
    input  logic                       ebreak,
    input  logic                       ecall,
    input  logic                       ld_addr_mis,
    input  logic                       st_addr_mis,
    input  logic [csr_pkg::xlen-1:0]   ins_pc,
    input  logic [csr_pkg::xlen-1:0]   mem_addr,
    input  csr_pkg::priv_e             priv,
    output logic                       trap,
    output csr_pkg::exc_cause_e        cause,
    output logic [csr_pkg::xlen-1:0]   tval
);

    logic any_exc;

    assign any_exc = ins_addr_mis || ill_ins || ebreak || ecall || ld_addr_mis || st_addr_mis;
    assign trap    = valid && any_exc;

    // first hit wins, fetch side before memory side
    always_comb begin
        cause = csr_pkg::exc_ins_mis;
        tval  = '0;
        if (ins_addr_mis) begin
            cause = csr_pkg::exc_ins_mis;
            tval  = ins_pc;
        end else if (ill_ins) begin
            cause = csr_pkg::exc_ill_ins; // tval stays zero
        end else if (ebreak) begin
            cause = csr_pkg::exc_break;
            tval  = ins_pc;
        end else if (ecall) begin
            // cause tells the handler which mode made the call
            if (priv == csr_pkg::priv_m) begin
                cause = csr_pkg::exc_ecall_m;
            end else begin
                cause = csr_pkg::exc_ecall_u;
            end
        end else if (ld_addr_mis) begin
            cause = csr_pkg::exc_ld_mis;
            tval  = mem_addr;
        end else if (st_addr_mis) begin
            cause = csr_pkg::exc_st_mis;
            tval  = mem_addr;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

    // datapath widths
    localparam int xlen      = 64;
    localparam int csr_idx_w = 12;

    // machine-mode CSR indices
    localparam logic [csr_idx_w-1:0] csr_mstatus       = 12'h300;
    localparam logic [csr_idx_w-1:0] csr_misa          = 12'h301;
    localparam logic [csr_idx_w-1:0] csr_mtvec         = 12'h305;
    localparam logic [csr_idx_w-1:0] csr_mcountinhibit = 12'h320;
    localparam logic [csr_idx_w-1:0] csr_mscratch      = 12'h340;
    localparam logic [csr_idx_w-1:0] csr_mepc          = 12'h341;
    localparam logic [csr_idx_w-1:0] csr_mcause        = 12'h342;
    localparam logic [csr_idx_w-1:0] csr_mtval         = 12'h343;
    localparam logic [csr_idx_w-1:0] csr_mcycle        = 12'hb00;
    localparam logic [csr_idx_w-1:0] csr_minstret      = 12'hb02;
    localparam logic [csr_idx_w-1:0] csr_mhartid       = 12'hf14;

    // user-level read-only aliases of the counters
    localparam logic [csr_idx_w-1:0] csr_cycle   = 12'hc00;
    localparam logic [csr_idx_w-1:0] csr_instret = 12'hc02;

    // mstatus field positions
    localparam int mstatus_mie_bit  = 3;
    localparam int mstatus_mpie_bit = 7;
    localparam int mstatus_mpp_lsb  = 11; // two bits wide

    // MXL = 2 (64 bit), extension I only
    localparam logic [xlen-1:0] misa_value = 64'h8000_0000_0000_0100;

    localparam logic [xlen-1:0] hart_id = 64'h0; // single hart

    typedef enum logic [1:0] {
        priv_u = 2'd0,
        priv_m = 2'd3
    } priv_e;

    // synchronous exception codes as written into mcause
    typedef enum logic [3:0] {
        exc_ins_mis = 4'd0,
        exc_ill_ins = 4'd2,
        exc_break   = 4'd3,
        exc_ld_mis  = 4'd4,
        exc_st_mis  = 4'd6,
        exc_ecall_u = 4'd8,
        exc_ecall_m = 4'd11
    } exc_cause_e;

endpackage

`default_nettype wire

// ==== hdl/csr_status.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_status (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     trap,
    input  logic                     m_ret,
    input  logic                     valid,
    input  logic                     write_mstatus,
    input  logic [csr_pkg::xlen-1:0] csr_data_w,
    output logic [csr_pkg::xlen-1:0] mstatus,
    output csr_pkg::priv_e           priv
);

    logic           mie_q;
    logic           mpie_q;
    csr_pkg::priv_e mpp_q;
    logic [1:0]     mpp_wr;

    assign mpp_wr = csr_data_w[csr_pkg::mstatus_mpp_lsb +: 2];

    always_ff @(posedge clk) begin
        if (rst) begin
            mie_q  <= 1'b0;
            mpie_q <= 1'b0;
            mpp_q  <= csr_pkg::priv_u;
            priv   <= csr_pkg::priv_m;
        end else if (trap) begin
            mpie_q <= mie_q;
            mie_q  <= 1'b0;
            mpp_q  <= priv;
            priv   <= csr_pkg::priv_m; // all traps go to machine mode
        end else if (valid && m_ret) begin
            mie_q  <= mpie_q;
            mpie_q <= 1'b1;
            priv   <= mpp_q;
            mpp_q  <= csr_pkg::priv_u;
        end else if (write_mstatus) begin
            mie_q  <= csr_data_w[csr_pkg::mstatus_mie_bit];
            mpie_q <= csr_data_w[csr_pkg::mstatus_mpie_bit];
            // only U and M exist, other MPP codes leave the field alone
            if (mpp_wr == 2'd3) begin
                mpp_q <= csr_pkg::priv_m;
            end else if (mpp_wr == 2'd0) begin
                mpp_q <= csr_pkg::priv_u;
            end
        end
    end

    always_comb begin
        mstatus = '0;
        mstatus[csr_pkg::mstatus_mie_bit]       = mie_q;
        mstatus[csr_pkg::mstatus_mpie_bit]      = mpie_q;
        mstatus[csr_pkg::mstatus_mpp_lsb +: 2]  = mpp_q;
    end

    // a trapping mret is not a return, we end up in machine mode with MIE off
    assert property (@(posedge clk) disable iff (rst)
        (valid && m_ret && trap) |=> (priv == csr_pkg::priv_m) && !mie_q);

endmodule

`default_nettype wire

// ==== hdl/csr_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          valid,
    input  logic                          csr_write,
    input  logic [csr_pkg::csr_idx_w-1:0] csr_read_index,
    input  logic [csr_pkg::csr_idx_w-1:0] csr_write_index,
    input  logic [csr_pkg::xlen-1:0]      csr_data_w,
    input  logic [csr_pkg::xlen-1:0]      ins_pc,
    input  logic [csr_pkg::xlen-1:0]      mem_addr,
    input  logic                          ins_addr_mis,
    input  logic                          ill_ins,
    input  logic                          ebreak,
    input  logic                          ecall,
    input  logic                          ld_addr_mis,
    input  logic                          st_addr_mis,
    input  logic                          m_ret,
    output logic [csr_pkg::xlen-1:0]      csr_data_r,
    output logic                          trap_taken,
    output logic [csr_pkg::xlen-1:0]      trap_pc,
    output logic [csr_pkg::xlen-1:0]      ret_pc,
    output csr_pkg::priv_e                priv
);

    logic                     trap;
    csr_pkg::exc_cause_e      cause;
    logic [csr_pkg::xlen-1:0] tval;

    logic [csr_pkg::xlen-1:0] mstatus, mtvec, mscratch, mepc, mcause, mtval;
    logic [csr_pkg::xlen-1:0] mcycle, minstret, mcountinhibit;

    logic write_mstatus, write_mtvec, write_mscratch, write_mepc, write_mcause;
    logic write_mtval, write_mcycle, write_minstret, write_mcountinhibit;

    assign trap_taken = trap;
    assign trap_pc    = mtvec; // low bits already zero in the register
    assign ret_pc     = mepc;

    csr_access i_csr_access (
        .valid, .csr_write, .trap, .csr_read_index, .csr_write_index,
        .mstatus, .mtvec, .mscratch, .mepc, .mcause, .mtval,
        .mcycle, .minstret, .mcountinhibit,
        .write_mstatus, .write_mtvec, .write_mscratch, .write_mepc, .write_mcause,
        .write_mtval, .write_mcycle, .write_minstret, .write_mcountinhibit,
        .csr_data_r
    );

    csr_exc_prio i_csr_exc_prio (
        .valid, .ins_addr_mis, .ill_ins, .ebreak, .ecall, .ld_addr_mis, .st_addr_mis,
        .ins_pc, .mem_addr, .priv, .trap, .cause, .tval
    );

    csr_status i_csr_status (
        .clk, .rst, .trap, .m_ret, .valid, .write_mstatus, .csr_data_w,
        .mstatus, .priv
    );

    csr_trap_regs i_csr_trap_regs (
        .clk, .rst, .trap, .cause, .tval, .ins_pc,
        .write_mtvec, .write_mepc, .write_mcause, .write_mtval, .write_mscratch,
        .csr_data_w, .mtvec, .mepc, .mcause, .mtval, .mscratch
    );

    csr_counters i_csr_counters (
        .clk, .rst, .valid, .trap,
        .write_mcycle, .write_minstret, .write_mcountinhibit,
        .csr_data_w, .mcycle, .minstret, .mcountinhibit
    );

endmodule

`default_nettype wire

// ==== hdl/csr_trap_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_trap_regs (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     trap,
    input  csr_pkg::exc_cause_e      cause,
    input  logic [csr_pkg::xlen-1:0] tval,
    input  logic [csr_pkg::xlen-1:0] ins_pc,
    input  logic                     write_mtvec,
    input  logic                     write_mepc,
    input  logic                     write_mcause,
    input  logic                     write_mtval,
    input  logic                     write_mscratch,
    input  logic [csr_pkg::xlen-1:0] csr_data_w,
    output logic [csr_pkg::xlen-1:0] mtvec,
    output logic [csr_pkg::xlen-1:0] mepc,
    output logic [csr_pkg::xlen-1:0] mcause,
    output logic [csr_pkg::xlen-1:0] mtval,
    output logic [csr_pkg::xlen-1:0] mscratch
);

    logic [csr_pkg::xlen-1:0] cause_ext;

    // exceptions only, so the interrupt bit stays clear
    assign cause_ext = {{(csr_pkg::xlen - $bits(cause)){1'b0}}, cause};

    // trap-side registers
    always_ff @(posedge clk) begin
        if (rst) begin
            mepc   <= '0;
            mcause <= '0;
            mtval  <= '0;
        end else if (trap) begin
            mepc   <= ins_pc;
            mcause <= cause_ext;
            mtval  <= tval;
        end else begin
            if (write_mepc) begin
                mepc <= {csr_data_w[csr_pkg::xlen-1:1], 1'b0}; // IALIGN 16 at most
            end
            if (write_mcause) begin
                mcause <= csr_data_w;
            end
            if (write_mtval) begin
                mtval <= csr_data_w;
            end
        end
    end

    // software-only registers, never touched by a trap
    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec    <= '0;
            mscratch <= '0;
        end else begin
            if (write_mtvec) begin
                mtvec <= {csr_data_w[csr_pkg::xlen-1:2], 2'b00}; // direct mode only
            end
            if (write_mscratch) begin
                mscratch <= csr_data_w;
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/csr_stim.txt ====
# op rd_idx wr_idx data rnd flags(ia ill brk ecall ld st) ins_pc mem_addr
# exp_rdata exp_trap exp_trap_pc exp_ret_pc exp_priv, rnd 1 randomizes data, rnd 2 expects it back
read 301 000 0 0 000000 0 0 8000000000000100 0 0 0 3
read f14 000 0 0 000000 0 0 0 0 0 0 3
read 7c0 000 0 0 000000 0 0 0 0 0 0 3
write 300 340 0 1 000000 0 0 0 0 0 0 3
read 340 000 0 2 000000 0 0 0 0 0 0 3
write 305 305 80000103 0 000000 0 0 0 0 0 0 3
write 305 341 1235 0 000000 0 0 80000100 0 80000100 0 3
mret 341 000 0 0 000000 0 0 1234 0 80000100 1234 3
read 300 000 0 0 000000 0 0 80 0 80000100 1234 0
instr 342 000 0 0 000100 4000 0 0 1 80000100 1234 0
read 342 000 0 0 000000 0 0 8 0 80000100 4000 3
read 300 000 0 0 000000 0 0 0 0 80000100 4000 3
write 343 340 deadbeef 0 001011 5000 6001 0 1 80000100 4000 3
read 342 000 0 0 000000 0 0 3 0 80000100 5000 3
read 343 000 0 0 000000 0 0 5000 0 80000100 5000 3
read 340 000 0 2 000000 0 0 0 0 80000100 5000 3
instr 300 000 0 0 000011 7000 8003 1800 1 80000100 5000 3
read 342 000 0 0 000000 0 0 4 0 80000100 7000 3
read 343 000 0 0 000000 0 0 8003 0 80000100 7000 3
instr 343 000 0 0 110000 9002 0 8003 1 80000100 7000 3
read 342 000 0 0 000000 0 0 0 0 80000100 9002 3
read 343 000 0 0 000000 0 0 9002 0 80000100 9002 3
write 342 342 55 0 010100 a000 0 0 1 80000100 9002 3
read 342 000 0 0 000000 0 0 2 0 80000100 a000 3
read 343 000 0 0 000000 0 0 0 0 80000100 a000 3
write 300 300 1808 0 000000 0 0 1800 0 80000100 a000 3
instr 300 000 0 0 001000 b000 0 1808 1 80000100 a000 3
read 300 000 0 0 000000 0 0 1880 0 80000100 b000 3
mret 300 000 0 0 000000 0 0 1880 0 80000100 b000 3
read 300 000 0 0 000000 0 0 88 0 80000100 b000 3
write 320 320 ffffffffffffffff 0 000000 0 0 0 0 80000100 b000 3
write 320 b00 0 1 000000 0 0 5 0 80000100 b000 3
read b00 000 0 2 000000 0 0 0 0 80000100 b000 3
instr c00 000 0 2 000000 0 0 0 0 80000100 b000 3
write 320 b02 0 1 000000 0 0 5 0 80000100 b000 3
instr b02 000 0 2 000000 0 0 0 0 80000100 b000 3
instr c02 000 0 2 000000 0 0 0 0 80000100 b000 3
write 320 b00 100 0 000000 0 0 5 0 80000100 b000 3
instr b00 000 0 0 000000 0 0 100 0 80000100 b000 3
instr b02 000 0 2 000000 0 0 0 0 80000100 b000 3

// ==== testbench/tb_csr_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_csr_top;

    logic                          clk;
    logic                          rst;
    logic                          valid;
    logic                          csr_write;
    logic [csr_pkg::csr_idx_w-1:0] csr_read_index;
    logic [csr_pkg::csr_idx_w-1:0] csr_write_index;
    logic [csr_pkg::xlen-1:0]      csr_data_w;
    logic [csr_pkg::xlen-1:0]      ins_pc;
    logic [csr_pkg::xlen-1:0]      mem_addr;
    logic ins_addr_mis, ill_ins, ebreak, ecall, ld_addr_mis, st_addr_mis, m_ret;
    logic [csr_pkg::xlen-1:0]      csr_data_r;
    logic                          trap_taken;
    logic [csr_pkg::xlen-1:0]      trap_pc;
    logic [csr_pkg::xlen-1:0]      ret_pc;
    csr_pkg::priv_e                priv;

    // one entry per stimulus line, op 0 read, 1 write, 2 instr, 3 mret
    logic [1:0]  line_op [0:63];
    logic [11:0] line_rd [0:63];
    logic [11:0] line_wr [0:63];
    logic [63:0] line_data [0:63];
    logic [1:0]  line_rnd [0:63];
    logic [5:0]  line_flags [0:63];
    logic [63:0] line_pc [0:63];
    logic [63:0] line_addr [0:63];
    logic [63:0] exp_rd [0:63];
    logic        exp_trap [0:63];
    logic [63:0] exp_tpc [0:63];
    logic [63:0] exp_rpc [0:63];
    logic [1:0]  exp_priv [0:63];

    int          n_lines;
    int          errors;
    int          i;
    logic        loaded;
    logic [63:0] last_rand; // data of the latest random line

    csr_top i_csr_top (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic load_stimulus();
        integer           fd;
        integer           cnt;
        logic [8*200-1:0] text;
        logic [8*8-1:0]   tok;
        logic [63:0]      f_rd, f_wr, f_data, f_pc, f_addr, f_exp, f_tpc, f_rpc;
        logic [5:0]       f_flags;
        integer           f_rnd, f_trap, f_priv;
        fd = $fopen("testbench/csr_stim.txt", "r");
        if (fd == 0) begin
            $display("stimulus file testbench/csr_stim.txt could not be opened");
            $display("Simulation FAILED");
            $fatal(1);
        end else begin
            while (!$feof(fd)) begin
                text = '0;
                tok  = '0;
                cnt  = $fgets(text, fd);
                cnt  = $sscanf(text, "%s", tok);
                if (cnt == 1 && tok != "#") begin  // skip blanks and comments
                    cnt = $sscanf(text, "%s %h %h %h %d %b %h %h %h %d %h %h %d", tok, f_rd,
                                  f_wr, f_data, f_rnd, f_flags, f_pc, f_addr, f_exp, f_trap,
                                  f_tpc, f_rpc, f_priv);
                    assert (cnt == 13 && n_lines < 64 && (tok == "read" || tok == "write" ||
                            tok == "instr" || tok == "mret"))
                    else begin
                        $display("stimulus line %0d is malformed or too many lines", n_lines);
                        $display("Simulation FAILED");
                        $fatal(1);
                    end
                    line_op[n_lines]    = (tok == "write") ? 2'd1 : (tok == "instr") ? 2'd2 :
                                          (tok == "mret") ? 2'd3 : 2'd0;
                    line_rd[n_lines]    = f_rd[11:0];
                    line_wr[n_lines]    = f_wr[11:0];
                    line_data[n_lines]  = f_data;
                    line_rnd[n_lines]   = f_rnd[1:0];
                    line_flags[n_lines] = f_flags;
                    line_pc[n_lines]    = f_pc;
                    line_addr[n_lines]  = f_addr;
                    exp_rd[n_lines]     = f_exp;
                    exp_trap[n_lines]   = f_trap[0];
                    exp_tpc[n_lines]    = f_tpc;
                    exp_rpc[n_lines]    = f_rpc;
                    exp_priv[n_lines]   = f_priv[1:0];
                    n_lines++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_line(input int n);
        logic [63:0] wdata;
        wdata = line_data[n];
        if (line_rnd[n] == 2'd1) begin
            wdata     = {$urandom, $urandom};
            last_rand = wdata;
        end
        valid           <= (line_op[n] != 2'd0);
        csr_write       <= (line_op[n] == 2'd1);
        m_ret           <= (line_op[n] == 2'd3);
        csr_read_index  <= line_rd[n];
        csr_write_index <= line_wr[n];
        csr_data_w      <= wdata;
        {ins_addr_mis, ill_ins, ebreak, ecall, ld_addr_mis, st_addr_mis} <= line_flags[n];
        ins_pc          <= line_pc[n];
        mem_addr        <= line_addr[n];
    endtask

    task automatic report_mismatch(input int n, input string what, input logic [63:0] got,
                                   input logic [63:0] exp);
        errors++;
        $display("mismatch at %0t: line %0d %s is %h, expected %h", $time, n, what, got, exp);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_line(input int n);
        logic [63:0] rd_exp;
        rd_exp = (line_rnd[n] == 2'd2) ? last_rand : exp_rd[n];
        assert (csr_data_r === rd_exp) else report_mismatch(n, "csr_data_r", csr_data_r, rd_exp);
        assert (trap_taken === exp_trap[n])
        else report_mismatch(n, "trap_taken", trap_taken, exp_trap[n]);
        assert (trap_pc === exp_tpc[n]) else report_mismatch(n, "trap_pc", trap_pc, exp_tpc[n]);
        assert (ret_pc === exp_rpc[n]) else report_mismatch(n, "ret_pc", ret_pc, exp_rpc[n]);
        assert (priv === exp_priv[n]) else report_mismatch(n, "priv", priv, exp_priv[n]);
    endtask

    initial begin
        wait (loaded);
        #((n_lines + 32) * 40); // reset, all lines and some slack
        $display("timeout: the stimulus did not finish in time");
        $display("Simulation FAILED");
        $fatal(1);
    end

    initial begin
        rst = 1'b1;
        valid = 1'b0;
        csr_write = 1'b0;
        csr_read_index = '0;
        csr_write_index = '0;
        csr_data_w = '0;
        ins_pc = '0;
        mem_addr = '0;
        {ins_addr_mis, ill_ins, ebreak, ecall, ld_addr_mis, st_addr_mis, m_ret} = '0;
        n_lines = 0;
        errors = 0;
        loaded = 1'b0;
        last_rand = '0;
        void'($urandom(32'h6d72));
        load_stimulus();
        loaded = 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        for (i = 0; i < n_lines; i++) begin
            @(posedge clk);
            apply_line(i);
            @(negedge clk); // outputs settled mid cycle
            check_line(i);
        end
        @(posedge clk);
        valid <= 1'b0;
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
